//--- exec_unit.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module exec_unit import mips_pkg::*; (
    input  logic                    valid_in,
    output logic                    ready_out,
    input  de_payload_t             de,
    output logic                    valid_out,
    input  logic                    ready_in,
    output commit_t                 commit,
    output logic                    wr_en,
    output logic [`MIPS_RNUM_W-1:0] wr_num,
    output logic [`MIPS_XLEN-1:0]   wr_data,
    output fwd_t                    fwd
);

    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] result;
    logic [`MIPS_XLEN-1:0] pc4;
    logic [`MIPS_XLEN-1:0] br_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic                  is_link;
    logic                  br_taken;

    assign valid_out = valid_in;
    assign ready_out = ready_in;

    // ==============================
    // alu
    // ==============================

    assign op_b = de.imm_sel ? de.imm_ext : de.rt_data;

    always_comb begin
        case (de.alu_op)
            ALU_ADD:  result = de.rs_data + op_b;
            ALU_SUB:  result = de.rs_data - op_b;
            ALU_AND:  result = de.rs_data & op_b;
            ALU_OR:   result = de.rs_data | op_b;
            ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(de.rs_data) < $signed(op_b)};
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            ALU_LINK: result = de.pc8;
            default:  result = '0;
        endcase
    end

    // ==============================
    // branch and jump
    // ==============================

    assign pc4         = de.pc + `MIPS_XLEN'd4;
    assign br_target   = pc4 + {de.imm_ext[`MIPS_XLEN-3:0], 2'b00};
    assign jump_target = {pc4[`MIPS_XLEN-1:`MIPS_XLEN-4], de.instr[25:0], 2'b00};
    assign is_link     = (de.alu_op == ALU_LINK);

    // jal is reported as an always taken transfer.
    assign br_taken = (de.is_branch && (de.rs_data == de.rt_data)) || is_link;

    always_comb begin
        commit.pc        = de.pc;
        commit.instr     = de.instr;
        commit.wr_en     = de.wr_en;
        commit.wr_num    = de.wr_num;
        commit.wr_data   = result;
        commit.br_taken  = br_taken;
        commit.br_target = is_link ? jump_target : br_target;
    end

    // the write lands on the edge that moves the item into the commit register.
    assign wr_en   = valid_in && ready_in && de.wr_en;
    assign wr_num  = de.wr_num;
    assign wr_data = result;

    assign fwd.valid   = valid_in && de.wr_en;
    assign fwd.wr_num  = de.wr_num;
    assign fwd.wr_data = result;

endmodule

//--- instr_decode.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module instr_decode import mips_pkg::*; (
    input  logic [`MIPS_XLEN-1:0]   in_pc,
    input  logic [`MIPS_XLEN-1:0]   in_instr,
    input  logic [`MIPS_XLEN-1:0]   rs_data,
    input  logic [`MIPS_XLEN-1:0]   rt_data,
    output logic [`MIPS_RNUM_W-1:0] rs_num,
    output logic [`MIPS_RNUM_W-1:0] rt_num,
    input  fwd_t                    fwd,
    output de_payload_t             de
);

    opcode_t                 opcode;
    funct_t                  funct;
    logic [`MIPS_RNUM_W-1:0] rd_num;
    logic [15:0]             imm16;
    logic [`MIPS_XLEN-1:0]   imm_sext;
    logic [`MIPS_XLEN-1:0]   imm_zext;
    logic [`MIPS_XLEN-1:0]   pc4;
    logic                    fwd_rs;
    logic                    fwd_rt;

    // ==============================
    // field split
    // ==============================

    assign opcode = opcode_t'(in_instr[31:26]);
    assign funct  = funct_t'(in_instr[5:0]);
    assign rs_num = in_instr[25:21];
    assign rt_num = in_instr[20:16];
    assign rd_num = in_instr[15:11];
    assign imm16  = in_instr[15:0];

    assign imm_sext = {{(`MIPS_XLEN-16){imm16[15]}}, imm16};
    assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, imm16};

    // pc+4 is the base for branch offsets, pc+8 is the return address.
    assign pc4 = in_pc + `MIPS_XLEN'd4;

    // the execute result wins over the register file, except for register 0.
    assign fwd_rs = fwd.valid && (fwd.wr_num == rs_num) && (rs_num != '0);
    assign fwd_rt = fwd.valid && (fwd.wr_num == rt_num) && (rt_num != '0);

    // ==============================
    // control decode
    // ==============================

    always_comb begin
        de           = '0;
        de.pc        = in_pc;
        de.instr     = in_instr;
        de.pc8       = pc4 + `MIPS_XLEN'd4;
        de.rs_data   = fwd_rs ? fwd.wr_data : rs_data;
        de.rt_data   = fwd_rt ? fwd.wr_data : rt_data;
        de.imm_ext   = imm_sext;
        de.alu_op    = ALU_NONE;
        de.imm_sel   = 1'b0;
        de.is_branch = 1'b0;
        de.wr_num    = '0;
        de.wr_en     = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                de.wr_num = rd_num;
                de.wr_en  = 1'b1;
                case (funct)
                    FN_ADDU: de.alu_op = ALU_ADD;
                    FN_SUBU: de.alu_op = ALU_SUB;
                    FN_AND:  de.alu_op = ALU_AND;
                    FN_OR:   de.alu_op = ALU_OR;
                    FN_SLT:  de.alu_op = ALU_SLT;
                    default: de.wr_en  = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                de.alu_op  = ALU_ADD;
                de.imm_sel = 1'b1;
                de.wr_num  = rt_num;
                de.wr_en   = 1'b1;
            end
            OP_ORI: begin
                de.alu_op  = ALU_OR;
                de.imm_sel = 1'b1;
                de.imm_ext = imm_zext;
                de.wr_num  = rt_num;
                de.wr_en   = 1'b1;
            end
            OP_LUI: begin
                de.alu_op  = ALU_LUI;
                de.imm_sel = 1'b1;
                de.imm_ext = imm_zext;
                de.wr_num  = rt_num;
                de.wr_en   = 1'b1;
            end
            OP_BEQ: begin
                de.is_branch = 1'b1;
            end
            OP_JAL: begin
                de.alu_op = ALU_LINK;
                de.wr_num = `MIPS_RNUM_W'(`MIPS_LINK_REG);
                de.wr_en  = 1'b1;
            end
            default: begin
                de.wr_en = 1'b0;
            end
        endcase
    end

endmodule

//--- mini_mips_core.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module mini_mips_core import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`MIPS_XLEN-1:0] in_pc,
    input  logic [`MIPS_XLEN-1:0] in_instr,
    output logic                  commit_valid,
    input  logic                  commit_ready,
    output commit_t               commit
);

    logic [`MIPS_RNUM_W-1:0] rs_num;
    logic [`MIPS_RNUM_W-1:0] rt_num;
    logic [`MIPS_XLEN-1:0]   rs_data;
    logic [`MIPS_XLEN-1:0]   rt_data;
    logic                    wr_en;
    logic [`MIPS_RNUM_W-1:0] wr_num;
    logic [`MIPS_XLEN-1:0]   wr_data;
    fwd_t                    fwd;
    de_payload_t             de_next;
    de_payload_t             de_q;
    logic                    de_valid;
    logic                    de_ready;
    commit_t                 ex_commit;
    logic                    ex_valid;
    logic                    ew_ready;

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_num  (wr_num),
        .wr_data (wr_data)
    );

    // ==============================
    // decode to execute
    // ==============================

    instr_decode u_decode (
        .in_pc    (in_pc),
        .in_instr (in_instr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .rs_num   (rs_num),
        .rt_num   (rt_num),
        .fwd      (fwd),
        .de       (de_next)
    );

    pipe_reg #(.payload_t(de_payload_t)) u_de_reg (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (in_valid),
        .ready_out (in_ready),
        .data_in   (de_next),
        .valid_out (de_valid),
        .ready_in  (de_ready),
        .data_out  (de_q)
    );

    // ==============================
    // execute to commit
    // ==============================

    exec_unit u_exec (
        .valid_in  (de_valid),
        .ready_out (de_ready),
        .de        (de_q),
        .valid_out (ex_valid),
        .ready_in  (ew_ready),
        .commit    (ex_commit),
        .wr_en     (wr_en),
        .wr_num    (wr_num),
        .wr_data   (wr_data),
        .fwd       (fwd)
    );

    pipe_reg #(.payload_t(commit_t)) u_ew_reg (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (ex_valid),
        .ready_out (ew_ready),
        .data_in   (ex_commit),
        .valid_out (commit_valid),
        .ready_in  (commit_ready),
        .data_out  (commit)
    );

endmodule

//--- mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// ==============================
// core widths
// ==============================

// data path and program counter width.
`define MIPS_XLEN 32

// number of general purpose registers.
`define MIPS_NREGS 32

// bits needed to name one register.
`define MIPS_RNUM_W 5

// jal always links through this register.
`define MIPS_LINK_REG 31

`endif

//--- mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

    // ==============================
    // instruction encodings
    // ==============================

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    // operations understood by the execute stage.
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI,
        ALU_LINK,
        ALU_NONE
    } alu_op_t;

    // ==============================
    // stage payloads
    // ==============================

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   instr;
        logic [`MIPS_XLEN-1:0]   pc8;
        logic [`MIPS_XLEN-1:0]   rs_data;
        logic [`MIPS_XLEN-1:0]   rt_data;
        logic [`MIPS_XLEN-1:0]   imm_ext;
        alu_op_t                 alu_op;
        logic                    imm_sel;
        logic                    is_branch;
        logic [`MIPS_RNUM_W-1:0] wr_num;
        logic                    wr_en;
    } de_payload_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   instr;
        logic                    wr_en;
        logic [`MIPS_RNUM_W-1:0] wr_num;
        logic [`MIPS_XLEN-1:0]   wr_data;
        logic                    br_taken;
        logic [`MIPS_XLEN-1:0]   br_target;
    } commit_t;

    // result of the instruction sitting in execute, not yet in the register file.
    typedef struct packed {
        logic                    valid;
        logic [`MIPS_RNUM_W-1:0] wr_num;
        logic [`MIPS_XLEN-1:0]   wr_data;
    } fwd_t;

endpackage

//--- pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    output logic     ready_out,
    input  payload_t data_in,
    output logic     valid_out,
    input  logic     ready_in,
    output payload_t data_out
);

    logic stall;

    // holding a valid item that downstream has not taken yet.
    assign stall     = valid_out && !ready_in;
    assign ready_out = !valid_out || ready_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            data_out  <= '0;
        end else if (!stall) begin
            valid_out <= valid_in;
            if (valid_in) begin
                data_out <= data_in;
            end else begin
                data_out <= '0;
            end
        end
    end

    // ==============================
    // handshake checks
    // ==============================

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        stall |=> valid_out && $stable(data_out));

    a_empty_after_reset: assert property (@(posedge clk)
        reset |=> !valid_out);

endmodule

//--- reg_file.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MIPS_RNUM_W-1:0] rs_num,
    input  logic [`MIPS_RNUM_W-1:0] rt_num,
    output logic [`MIPS_XLEN-1:0]   rs_data,
    output logic [`MIPS_XLEN-1:0]   rt_data,
    input  logic                    wr_en,
    input  logic [`MIPS_RNUM_W-1:0] wr_num,
    input  logic [`MIPS_XLEN-1:0]   wr_data
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
    logic                  wr_live;

    // writes to register 0 are dropped.
    assign wr_live = wr_en && (wr_num != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_num] <= wr_data;
        end
    end

    // a read of the register being written this cycle sees the new value.
    always_comb begin
        if (rs_num == '0) rs_data = '0;
        else if (wr_live && wr_num == rs_num) rs_data = wr_data;
        else rs_data = regs[rs_num];

        if (rt_num == '0) rt_data = '0;
        else if (wr_live && wr_num == rt_num) rt_data = wr_data;
        else rt_data = regs[rt_num];
    end

    a_reg0_zero: assert property (@(posedge clk) disable iff (reset)
        wr_en && wr_num == '0 |=> regs[0] == '0);

endmodule

//--- sim.f
+incdir+.
mips_pkg.sv
reg_file.sv
instr_decode.sv
pipe_reg.sv
exec_unit.sv
mini_mips_core.sv
tb_mini_mips_core.sv

//--- tb_mini_mips_core.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module tb_mini_mips_core import mips_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int N_PER_TEST  = 40;
    localparam int TOTAL_INSTR = 6 * N_PER_TEST;
    localparam int WATCHDOG_NS = (TOTAL_INSTR * 20 + 200) * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    logic [`MIPS_XLEN-1:0] in_pc;
    logic [`MIPS_XLEN-1:0] in_instr;
    logic                  commit_valid;
    logic                  commit_ready;
    commit_t               commit;

    logic [31:0] lcg_state = 32'h1438;
    logic [31:0] next_pc = 32'h0040_0000;
    logic [31:0] model_regs [`MIPS_NREGS];
    logic [63:0] sent_q [$];
    commit_t     exp_commit;
    logic        exp_valid;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    mini_mips_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (in_pc),
        .in_instr     (in_instr),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

    always #(CLK_PERIOD / 2) clk = !clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    task automatic log_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        error_count++;
    endtask

    // ==============================
    // stimulus
    // ==============================

    // registers stay within 0 to 7 so that results feed each other often.
    function automatic logic [31:0] gen_instr(input int mode);
        logic [31:0] r;
        logic [15:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          kind;
        r   = next_rand();
        imm = next_rand();
        rs  = {2'b00, r[2:0]};
        rt  = {2'b00, r[5:3]};
        rd  = {2'b00, r[8:6]};
        if (mode == 4 && r[9]) begin
            rd = '0;
            rt = '0;
        end
        if (mode == 4 && r[10]) rs = '0;
        if (mode == 3 && r[20]) rt = rs;
        case (mode)
            0: kind = r[18:16] % 5;
            1: kind = 5 + r[17:16] % 3;
            3: kind = r[19:16] % 10;
            default: kind = r[19:16] % 8;
        endcase
        case (kind)
            0: return {6'h00, rs, rt, rd, 5'h00, 6'h21};
            1: return {6'h00, rs, rt, rd, 5'h00, 6'h23};
            2: return {6'h00, rs, rt, rd, 5'h00, 6'h24};
            3: return {6'h00, rs, rt, rd, 5'h00, 6'h25};
            4: return {6'h00, rs, rt, rd, 5'h00, 6'h2a};
            5: return {6'h0d, rs, rt, imm};
            6: return {6'h09, rs, rt, imm};
            7: return {6'h0f, 5'h00, rt, imm};
            8: return {6'h04, rs, rt, imm};
            default: return {6'h03, r[25:0]};
        endcase
    endfunction

    // ==============================
    // reference model
    // ==============================

    function automatic commit_t model_commit(input logic [63:0] item);
        commit_t     c;
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        pc          = item[63:32];
        ins         = item[31:0];
        a           = model_regs[ins[25:21]];
        b           = model_regs[ins[20:16]];
        sx          = {{16{ins[15]}}, ins[15:0]};
        c           = '0;
        c.pc        = pc;
        c.instr     = ins;
        c.wr_en     = 1'b1;
        c.wr_num    = ins[20:16];
        case (ins[31:26])
            6'h00: begin
                c.wr_num = ins[15:11];
                case (ins[5:0])
                    6'h21: c.wr_data = a + b;
                    6'h23: c.wr_data = a - b;
                    6'h24: c.wr_data = a & b;
                    6'h25: c.wr_data = a | b;
                    6'h2a: c.wr_data = {31'd0, $signed(a) < $signed(b)};
                    default: c.wr_en = 1'b0;
                endcase
            end
            6'h09: c.wr_data = a + sx;
            6'h0d: c.wr_data = a | {16'h0000, ins[15:0]};
            6'h0f: c.wr_data = {ins[15:0], 16'h0000};
            6'h04: begin
                c.wr_en     = 1'b0;
                c.br_taken  = (a == b);
                c.br_target = pc + 32'd4 + (sx << 2);
            end
            6'h03: begin
                c.wr_num    = `MIPS_LINK_REG;
                c.wr_data   = pc + 32'd8;
                c.br_taken  = 1'b1;
                c.br_target = {pc[31:28], ins[25:0], 2'b00};
            end
            default: c.wr_en = 1'b0;
        endcase
        return c;
    endfunction

    // the model retires one instruction per commit handshake, then sets up the next expectation.
    always @(posedge clk) begin : model_update
        commit_t done;
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) model_regs[i] = '0;
            sent_q.delete();
        end else begin
            if (commit_valid && commit_ready && sent_q.size() != 0) begin
                done = model_commit(sent_q.pop_front());
                if (done.wr_en && done.wr_num != '0) model_regs[done.wr_num] = done.wr_data;
            end
            if (in_valid && in_ready) sent_q.push_back({in_pc, in_instr});
        end
        exp_valid  = (sent_q.size() != 0);
        exp_commit = exp_valid ? model_commit(sent_q[0]) : '0;
    end

    // ==============================
    // checks
    // ==============================

    a_no_extra: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> exp_valid)
        else log_error("commit with no instruction outstanding");

    a_pc_instr: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> commit.pc == exp_commit.pc &&
            commit.instr == exp_commit.instr)
        else log_error($sformatf("pc/instr %h/%h, expected %h/%h", $sampled(commit.pc),
            $sampled(commit.instr), $sampled(exp_commit.pc), $sampled(exp_commit.instr)));

    a_wr_en: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> commit.wr_en == exp_commit.wr_en)
        else log_error($sformatf("wr_en wrong for instr %h", $sampled(commit.instr)));

    a_wr_value: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready && exp_commit.wr_en |->
            commit.wr_num == exp_commit.wr_num && commit.wr_data == exp_commit.wr_data)
        else log_error($sformatf("write r%0d=%h, expected r%0d=%h", $sampled(commit.wr_num),
            $sampled(commit.wr_data), $sampled(exp_commit.wr_num),
            $sampled(exp_commit.wr_data)));

    a_branch: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> commit.br_taken == exp_commit.br_taken)
        else log_error($sformatf("br_taken wrong for instr %h", $sampled(commit.instr)));

    // a beq reports its target whether or not it is taken.
    a_target: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready &&
            (exp_commit.br_taken || exp_commit.instr[31:26] == 6'h04) |->
            commit.br_target == exp_commit.br_target)
        else log_error($sformatf("target %h, expected %h", $sampled(commit.br_target),
            $sampled(exp_commit.br_target)));

    a_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else log_error("commit changed while stalled");

    a_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !commit_valid && in_ready)
        else log_error("core not idle after reset");

    // ==============================
    // test sequencing
    // ==============================

    task automatic run_test(input string name, input int mode, input int gap_pct,
                            input int stall_pct, input bit check_final);
        int sent;
        int errs_before;
        sent        = 0;
        errs_before = error_count;
        while (sent < N_PER_TEST) begin
            @(posedge clk);
            commit_ready <= (next_rand() % 100) >= stall_pct;
            if (in_valid && in_ready) sent++;
            if (!(in_valid && !in_ready)) begin
                if (sent < N_PER_TEST && (next_rand() % 100) >= gap_pct) begin
                    in_valid <= 1'b1;
                    in_pc    <= next_pc;
                    in_instr <= gen_instr(mode);
                    next_pc  = next_pc + 32'd4;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
        forever begin
            @(negedge clk);
            if (sent_q.size() == 0) break;
            @(posedge clk);
            commit_ready <= (next_rand() % 100) >= stall_pct;
        end
        if (check_final) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                assert (i_dut.u_reg_file.regs[i] == model_regs[i])
                    else log_error($sformatf("final r%0d=%h, expected %h", i,
                        i_dut.u_reg_file.regs[i], model_regs[i]));
            end
        end
        @(posedge clk);
        commit_ready <= 1'b1;
        if (error_count == errs_before) tests_passed++;
        else tests_failed++;
        $display("test %s: %0d errors", name, error_count - errs_before);
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the core stopped committing before all tests finished");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_instr     = '0;
        commit_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        run_test("r-type results", 0, 25, 20, 1'b0);
        run_test("immediate forms", 1, 25, 20, 1'b0);
        run_test("dependent back-to-back", 2, 0, 0, 1'b0);
        run_test("back-pressure", 2, 10, 60, 1'b1);
        run_test("control", 3, 20, 20, 1'b0);
        apply_reset();
        run_test("reset and register 0", 4, 20, 20, 1'b1);
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
